/* logic/imu_defs_macros.svh */
`ifndef IMU_DEFS_MACROS_SVH
`define IMU_DEFS_MACROS_SVH

// SHTP channel numbers
`define SHTP_CHAN_CONTROL 8'h02
`define SHTP_CHAN_REPORTS 8'h03
`define SHTP_CHAN_GYRO_RV 8'h05

// Sensor report IDs
`define RID_ROT_VECTOR    8'h05
`define RID_GYRO          8'h02

// Length, channel and sequence bytes
`define SHTP_HDR_BYTES    4

// Delays in clock cycles, scaled down for simulation
`define POWERUP_CYCLES    200
`define WAKE_CYCLES       45   // PS0/WAKE low time
`define INT_TIMEOUT       1500
`define RESP_TIMEOUT      300  // Wait for a command response

`endif

/* logic/imu_pkg.sv */
package imu_pkg;

    typedef logic [7:0]         spi_byte_t;   // One byte on the SPI bus
    typedef logic [15:0]        shtp_len_t;   // Frame length, header included
    typedef logic signed [15:0] imu_word_t;   // Q-format sensor field
    typedef logic [11:0]        delay_cnt_t;
    typedef logic [1:0]         init_step_t;  // 3 means all commands done

    // Destination of one decoded sensor field
    typedef enum logic [2:0] {
        field_quat_x,
        field_quat_y,
        field_quat_z,
        field_quat_w,
        field_gyro_x,
        field_gyro_y,
        field_gyro_z
    } field_sel_t;

    typedef enum logic [2:0] {
        seq_power_up,
        seq_wake,
        seq_wait_int,
        seq_send_cmd,
        seq_wait_resp,
        seq_read_frame,
        seq_idle
    } seq_state_t;

endpackage

/* logic/shtp_sequencer.sv */
`timescale 1ns/1ps
`include "imu_defs_macros.svh"

module shtp_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               int_n,         // Sensor data ready, active low
    input  logic               spi_rx_valid,
    input  logic               byte_req,
    input  logic               frame_done,
    output logic               spi_start,
    output imu_pkg::spi_byte_t spi_tx_data,
    output logic               cs_n,
    output logic               ps0_wake,
    output logic               frame_start,
    output logic               sensor_mode,
    output logic               initialized,
    output logic               error
);
    import imu_pkg::*;

    seq_state_t state;
    delay_cnt_t delay_cnt;
    init_step_t step;
    shtp_len_t  cmd_idx;   // Byte index within the current command
    logic       int_meta;
    logic       int_sync;

    // Command ROM, product ID request then two set-feature commands
    function automatic spi_byte_t cmd_byte(init_step_t s, shtp_len_t idx);
        spi_byte_t b;
        b = 8'h00;
        if (s == 2'd0) begin
            case (idx)
                16'd0:   b = 8'h05;               // Length LSB
                16'd2:   b = `SHTP_CHAN_CONTROL;
                16'd4:   b = 8'hF9;               // Product ID request
                default: b = 8'h00;
            endcase
        end else begin
            case (idx)
                16'd0:   b = 8'd17;
                16'd2:   b = `SHTP_CHAN_CONTROL;
                16'd3:   b = {6'd0, s};            // Sequence number
                16'd4:   b = 8'hFD;                // Set feature
                16'd5:   b = (s == 2'd1) ? `RID_ROT_VECTOR : `RID_GYRO;
                16'd9:   b = 8'h20;                // 20 ms report interval
                16'd10:  b = 8'h4E;
                default: b = 8'h00;
            endcase
        end
        return b;
    endfunction

    function automatic shtp_len_t cmd_last(init_step_t s);
        return (s == 2'd0) ? 16'd4 : 16'd16;
    endfunction

    // Two-flop synchronizer for the interrupt pin
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_meta <= 1'b1;
            int_sync <= 1'b1;
        end else begin
            int_meta <= int_n;
            int_sync <= int_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= seq_power_up;
            delay_cnt   <= '0;
            step        <= '0;
            cmd_idx     <= '0;
            spi_start   <= 1'b0;
            spi_tx_data <= '0;
            cs_n        <= 1'b1;
            ps0_wake    <= 1'b1;
            frame_start <= 1'b0;
            sensor_mode <= 1'b0;
            initialized <= 1'b0;
            error       <= 1'b0;
        end else begin
            spi_start   <= 1'b0;
            frame_start <= 1'b0;
            case (state)
                seq_power_up: begin
                    if (delay_cnt == delay_cnt_t'(`POWERUP_CYCLES - 1)) begin
                        delay_cnt <= '0;
                        ps0_wake  <= 1'b0;
                        state     <= seq_wake;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                seq_wake: begin
                    if (delay_cnt == delay_cnt_t'(`WAKE_CYCLES - 1)) begin
                        delay_cnt <= '0;
                        ps0_wake  <= 1'b1;
                        state     <= seq_wait_int;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                seq_wait_int: begin
                    if (!int_sync) begin
                        cs_n        <= 1'b0;
                        cmd_idx     <= '0;
                        spi_start   <= 1'b1;
                        spi_tx_data <= cmd_byte(step, '0);
                        state       <= seq_send_cmd;
                    end else if (delay_cnt == delay_cnt_t'(`INT_TIMEOUT - 1)) begin
                        error       <= 1'b1;   // Sticky, sequence starts over
                        step        <= '0;
                        sensor_mode <= 1'b0;
                        delay_cnt   <= '0;
                        state       <= seq_power_up;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                seq_send_cmd: begin
                    if (spi_rx_valid) begin
                        if (cmd_idx == cmd_last(step)) begin
                            cs_n      <= 1'b1;
                            delay_cnt <= '0;
                            state     <= seq_wait_resp;
                            if (step == 2'd2)
                                sensor_mode <= 1'b1;
                        end else begin
                            cmd_idx     <= cmd_idx + 1'b1;
                            spi_start   <= 1'b1;
                            spi_tx_data <= cmd_byte(step, cmd_idx + 1'b1);
                        end
                    end
                end
                seq_wait_resp: begin
                    if (!int_sync) begin
                        cs_n        <= 1'b0;
                        spi_start   <= 1'b1;
                        spi_tx_data <= 8'h00;
                        frame_start <= 1'b1;
                        state       <= seq_read_frame;
                    end else if (delay_cnt == delay_cnt_t'(`RESP_TIMEOUT - 1)) begin
                        error       <= 1'b1;
                        step        <= '0;
                        sensor_mode <= 1'b0;
                        delay_cnt   <= '0;
                        state       <= seq_power_up;
                    end else begin
                        delay_cnt <= delay_cnt + 1'b1;
                    end
                end
                seq_read_frame: begin
                    if (frame_done) begin
                        cs_n      <= 1'b1;
                        delay_cnt <= '0;
                        if (step != 2'd3)
                            step <= step + 1'b1;
                        if (step == 2'd2)
                            initialized <= 1'b1;   // Third response read
                        state <= (step >= 2'd2) ? seq_idle : seq_wait_int;
                    end else if (byte_req) begin
                        spi_start   <= 1'b1;
                        spi_tx_data <= 8'h00;   // Dummy byte while reading
                    end
                end
                seq_idle: begin
                    if (!int_sync) begin
                        cs_n        <= 1'b0;
                        spi_start   <= 1'b1;
                        spi_tx_data <= 8'h00;
                        frame_start <= 1'b1;
                        state       <= seq_read_frame;
                    end
                end
                default: state <= seq_power_up;
            endcase
        end
    end

endmodule

/* logic/shtp_frame_decoder.sv */
`timescale 1ns/1ps
`include "imu_defs_macros.svh"

module shtp_frame_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                frame_start,
    input  logic                sensor_mode,
    input  logic                spi_rx_valid,
    input  imu_pkg::spi_byte_t  spi_rx_data,
    output logic                byte_req,
    output logic                frame_done,
    output logic                field_we,
    output imu_pkg::field_sel_t field_sel,
    output imu_pkg::imu_word_t  field_value
);
    import imu_pkg::*;

    logic       active;      // Inside a read frame
    shtp_len_t  byte_cnt;    // Index of the byte now arriving
    shtp_len_t  frame_len;
    shtp_len_t  pay_idx;
    spi_byte_t  chan;
    spi_byte_t  report_id;
    spi_byte_t  lsb_q;       // Low byte of the field in progress
    logic [2:0] pair;
    logic       take;
    logic       field_hit;
    logic       end_frame;

    assign pay_idx = byte_cnt - shtp_len_t'(`SHTP_HDR_BYTES);
    assign pair    = pay_idx[3:1] - 3'd2;   // Payload 4..11 gives fields 0..3
    assign take    = sensor_mode &&
                     (chan == `SHTP_CHAN_REPORTS || chan == `SHTP_CHAN_GYRO_RV);

    // MSB byte of a field that belongs to a known report
    assign field_hit = take && pay_idx >= 16'd4 && pay_idx <= 16'd11 && pay_idx[0] &&
                       (report_id == `RID_ROT_VECTOR ||
                        (report_id == `RID_GYRO && pair != 3'd3));

    // Short frames stop right after the header
    assign end_frame = (byte_cnt >= shtp_len_t'(`SHTP_HDR_BYTES - 1)) &&
                       (byte_cnt + 16'd1 >= frame_len);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            byte_cnt   <= '0;
            byte_req   <= 1'b0;
            frame_done <= 1'b0;
            field_we   <= 1'b0;
        end else begin
            byte_req   <= 1'b0;
            frame_done <= 1'b0;
            field_we   <= spi_rx_valid && active && field_hit;
            if (frame_start) begin
                active   <= 1'b1;
                byte_cnt <= '0;
            end else if (spi_rx_valid && active) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (end_frame) begin
                    frame_done <= 1'b1;
                    active     <= 1'b0;
                end else begin
                    byte_req <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (spi_rx_valid && active) begin
            case (byte_cnt)
                16'd0:   frame_len[7:0]  <= spi_rx_data;
                16'd1:   frame_len[15:8] <= {1'b0, spi_rx_data[6:0]}; // No continuation bit
                16'd2:   chan            <= spi_rx_data;
                default: ;   // Sequence byte is skipped
            endcase
            if (take && pay_idx == 16'd0)
                report_id <= spi_rx_data;
            if (!pay_idx[0])
                lsb_q <= spi_rx_data;
            field_value <= {spi_rx_data, lsb_q};   // Little endian pair
            field_sel   <= (report_id == `RID_ROT_VECTOR) ? field_sel_t'(pair)
                                                          : field_sel_t'(pair + 3'd4);
        end
    end

endmodule

/* logic/imu_sample_regs.sv */
`timescale 1ns/1ps

module imu_sample_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                field_we,
    input  imu_pkg::field_sel_t field_sel,
    input  imu_pkg::imu_word_t  field_value,
    output imu_pkg::imu_word_t  quat_w,
    output imu_pkg::imu_word_t  quat_x,
    output imu_pkg::imu_word_t  quat_y,
    output imu_pkg::imu_word_t  quat_z,
    output imu_pkg::imu_word_t  gyro_x,
    output imu_pkg::imu_word_t  gyro_y,
    output imu_pkg::imu_word_t  gyro_z,
    output logic                quat_valid,
    output logic                gyro_valid
);
    import imu_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            quat_w     <= '0;
            quat_x     <= '0;
            quat_y     <= '0;
            quat_z     <= '0;
            gyro_x     <= '0;
            gyro_y     <= '0;
            gyro_z     <= '0;
            quat_valid <= 1'b0;
            gyro_valid <= 1'b0;
        end else begin
            // Last field of each report marks the sample complete
            quat_valid <= field_we && (field_sel == field_quat_w);
            gyro_valid <= field_we && (field_sel == field_gyro_z);
            if (field_we) begin
                case (field_sel)
                    field_quat_x: quat_x <= field_value;
                    field_quat_y: quat_y <= field_value;
                    field_quat_z: quat_z <= field_value;
                    field_quat_w: quat_w <= field_value;
                    field_gyro_x: gyro_x <= field_value;
                    field_gyro_y: gyro_y <= field_value;
                    field_gyro_z: gyro_z <= field_value;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* logic/bno_shtp_top.sv */
`timescale 1ns/1ps

module bno_shtp_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               int_n,
    input  logic               spi_rx_valid,
    input  imu_pkg::spi_byte_t spi_rx_data,
    output logic               spi_start,
    output imu_pkg::spi_byte_t spi_tx_data,
    output logic               cs_n,
    output logic               ps0_wake,
    output imu_pkg::imu_word_t quat_w,
    output imu_pkg::imu_word_t quat_x,
    output imu_pkg::imu_word_t quat_y,
    output imu_pkg::imu_word_t quat_z,
    output imu_pkg::imu_word_t gyro_x,
    output imu_pkg::imu_word_t gyro_y,
    output imu_pkg::imu_word_t gyro_z,
    output logic               quat_valid,
    output logic               gyro_valid,
    output logic               initialized,
    output logic               error
);
    import imu_pkg::*;

    logic       byte_req;
    logic       frame_done;
    logic       frame_start;
    logic       sensor_mode;
    logic       field_we;
    field_sel_t field_sel;
    imu_word_t  field_value;

    shtp_sequencer shtp_sequencer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .int_n        (int_n),
        .spi_rx_valid (spi_rx_valid),
        .byte_req     (byte_req),
        .frame_done   (frame_done),
        .spi_start    (spi_start),
        .spi_tx_data  (spi_tx_data),
        .cs_n         (cs_n),
        .ps0_wake     (ps0_wake),
        .frame_start  (frame_start),
        .sensor_mode  (sensor_mode),
        .initialized  (initialized),
        .error        (error)
    );

    // Watches every received byte, acts only inside a frame
    shtp_frame_decoder shtp_frame_decoder_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_start  (frame_start),
        .sensor_mode  (sensor_mode),
        .spi_rx_valid (spi_rx_valid),
        .spi_rx_data  (spi_rx_data),
        .byte_req     (byte_req),
        .frame_done   (frame_done),
        .field_we     (field_we),
        .field_sel    (field_sel),
        .field_value  (field_value)
    );

    imu_sample_regs imu_sample_regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .field_we     (field_we),
        .field_sel    (field_sel),
        .field_value  (field_value),
        .quat_w       (quat_w),
        .quat_x       (quat_x),
        .quat_y       (quat_y),
        .quat_z       (quat_z),
        .gyro_x       (gyro_x),
        .gyro_y       (gyro_y),
        .gyro_z       (gyro_z),
        .quat_valid   (quat_valid),
        .gyro_valid   (gyro_valid)
    );

endmodule

/* bench/bno_shtp_asserts.sv */
`timescale 1ns/1ps

module bno_shtp_asserts (
    input logic clk,
    input logic rst_n,
    input logic spi_start,
    input logic cs_n,
    input logic quat_valid,
    input logic gyro_valid,
    input logic initialized
);

    int assert_errors = 0;   // Count of failed properties

    // Every byte exchange happens inside a selected frame
    start_needs_cs: assert property (@(posedge clk) disable iff (!rst_n) spi_start |-> !cs_n)
        else begin
            $error("spi_start raised while cs_n is high");
            assert_errors++;
        end

    start_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
                                         spi_start |=> !spi_start)
        else begin
            $error("spi_start held for two cycles");
            assert_errors++;
        end

    valids_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                                       !(quat_valid && gyro_valid))
        else begin
            $error("quat_valid and gyro_valid high together");
            assert_errors++;
        end

    // Only a reset may clear it
    init_holds: assert property (@(posedge clk) disable iff (!rst_n) !$fell(initialized))
        else begin
            $error("initialized fell without reset");
            assert_errors++;
        end

endmodule

bind bno_shtp_top bno_shtp_asserts bno_shtp_asserts_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .spi_start   (spi_start),
    .cs_n        (cs_n),
    .quat_valid  (quat_valid),
    .gyro_valid  (gyro_valid),
    .initialized (initialized)
);

/* bench/bno_shtp_tb.sv */
`timescale 1ns/1ps
`include "imu_defs_macros.svh"

module bno_shtp_tb;
    import imu_pkg::*;

    localparam int MAX_CYCLES = 30000;   // Whole run needs about 4k cycles

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      int_n = 1'b1;
    logic      spi_rx_valid = 1'b0;
    spi_byte_t spi_rx_data = 8'h00;
    logic      spi_start;
    spi_byte_t spi_tx_data;
    logic      cs_n;
    logic      ps0_wake;
    imu_word_t quat_w;
    imu_word_t quat_x;
    imu_word_t quat_y;
    imu_word_t quat_z;
    imu_word_t gyro_x;
    imu_word_t gyro_y;
    imu_word_t gyro_z;
    logic      quat_valid;
    logic      gyro_valid;
    logic      initialized;
    logic      error;

    spi_byte_t resp_q[$];    // Bytes the sensor returns
    spi_byte_t tx_log[$];    // Bytes the controller sent
    imu_word_t fld [0:3];    // Fields of the last queued report
    int        rx_wait = 0;
    int        cycles = 0;
    int        quat_pulses = 0;
    int        gyro_pulses = 0;
    int        seq_num = 0;
    string     test_name = "none";

    bno_shtp_top bno_shtp_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .int_n        (int_n),
        .spi_rx_valid (spi_rx_valid),
        .spi_rx_data  (spi_rx_data),
        .spi_start    (spi_start),
        .spi_tx_data  (spi_tx_data),
        .cs_n         (cs_n),
        .ps0_wake     (ps0_wake),
        .quat_w       (quat_w),
        .quat_x       (quat_x),
        .quat_y       (quat_y),
        .quat_z       (quat_z),
        .gyro_x       (gyro_x),
        .gyro_y       (gyro_y),
        .gyro_z       (gyro_z),
        .quat_valid   (quat_valid),
        .gyro_valid   (gyro_valid),
        .initialized  (initialized),
        .error        (error)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: test %s still running after %0d cycles", test_name, MAX_CYCLES);
            $display("Regression failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    always @(posedge clk) begin
        if (quat_valid)
            quat_pulses <= quat_pulses + 1;
        if (gyro_valid)
            gyro_pulses <= gyro_pulses + 1;
    end

    // Sensor side of the SPI byte exchange
    always @(posedge clk) begin
        spi_rx_valid <= 1'b0;
        if (spi_start) begin
            tx_log.push_back(spi_tx_data);
            rx_wait <= 1 + int'($urandom % 6);
        end else if (rx_wait == 1) begin
            spi_rx_valid <= 1'b1;
            if (resp_q.size() > 0)
                spi_rx_data <= resp_q.pop_front();
            else
                spi_rx_data <= 8'h00;   // Idle bus
            rx_wait <= 0;
        end else if (rx_wait > 1) begin
            rx_wait <= rx_wait - 1;
        end
    end

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            $display("Regression failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic apply_reset;
        rst_n <= 1'b0;
        int_n <= 1'b1;
        resp_q.delete();
        tx_log.delete();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    // Hold the interrupt until the controller selects, then let the transfer finish
    task automatic run_transfer;
        tx_log.delete();
        int_n <= 1'b0;
        @(posedge clk);
        while (cs_n)
            @(posedge clk);
        int_n <= 1'b1;
        while (!cs_n)
            @(posedge clk);
        repeat (3) @(posedge clk);   // Valid pulses trail the last field byte
    endtask

    task automatic push_header(input int len, input spi_byte_t chan, input logic cont);
        resp_q.push_back(len[7:0]);
        resp_q.push_back({cont, len[14:8]});   // Bit 15 is the continuation flag
        resp_q.push_back(chan);
        resp_q.push_back(spi_byte_t'(seq_num));
        seq_num++;
    endtask

    // 14-byte payload, fields little endian from payload byte 4
    task automatic push_report(input spi_byte_t chan, input spi_byte_t rid, input logic cont);
        spi_byte_t b [0:13];
        int        i;
        for (i = 0; i < 14; i++)
            b[i] = spi_byte_t'($urandom);
        b[0] = rid;
        push_header(18, chan, cont);
        for (i = 0; i < 14; i++)
            resp_q.push_back(b[i]);
        for (i = 0; i < 4; i++)
            fld[i] = {b[5 + 2 * i], b[4 + 2 * i]};
    endtask

    task automatic test_reset_values;
        test_name = "reset_values";
        check_value("cs_n", 1, cs_n);
        check_value("ps0_wake", 1, ps0_wake);
        check_value("spi_start", 0, spi_start);
        check_value("quat_valid", 0, quat_valid);
        check_value("gyro_valid", 0, gyro_valid);
        check_value("initialized", 0, initialized);
        check_value("error", 0, error);
        check_value("words", 0, {quat_w, quat_x, quat_y, quat_z, gyro_x, gyro_y, gyro_z});
    endtask

    task automatic test_initialization;
        logic [7:0] rom [0:16];
        int         len;
        int         step;
        int         i;
        test_name = "initialization";
        while (ps0_wake)
            @(posedge clk);
        while (!ps0_wake)
            @(posedge clk);
        for (step = 0; step < 3; step++) begin
            for (i = 0; i < 17; i++)
                rom[i] = 8'h00;
            if (step == 0) begin
                len = 5;          // Product ID request
                rom[0] = 8'h05;
                rom[2] = 8'h02;
                rom[4] = 8'hF9;
            end else begin
                len = 17;
                rom[0] = 8'h11;
                rom[2] = 8'h02;
                rom[3] = step[7:0];
                rom[4] = 8'hFD;   // Set feature
                rom[5] = (step == 1) ? 8'h05 : 8'h02;
                rom[9] = 8'h20;   // 20000 us interval
                rom[10] = 8'h4E;
            end
            run_transfer();
            check_value("command length", len, tx_log.size());
            for (i = 0; i < len; i++)
                check_value($sformatf("command byte %0d", i), rom[i], tx_log[i]);
            push_header(9, 8'h02, 1'b0);
            for (i = 0; i < 5; i++)
                resp_q.push_back(spi_byte_t'($urandom));
            run_transfer();
            check_value("response length", 9, tx_log.size());
            for (i = 0; i < 9; i++)
                check_value($sformatf("read byte %0d", i), 0, tx_log[i]);
        end
        check_value("initialized", 1, initialized);
        check_value("error", 0, error);
    endtask

    task automatic test_rotation_vector;
        int          q0;
        int          g0;
        logic [47:0] gyro_before;
        test_name = "rotation_vector";
        q0 = quat_pulses;
        g0 = gyro_pulses;
        gyro_before = {gyro_x, gyro_y, gyro_z};
        push_report(8'h03, 8'h05, 1'b0);
        run_transfer();
        check_value("quat_valid pulses", q0 + 1, quat_pulses);
        check_value("gyro_valid pulses", g0, gyro_pulses);
        check_value("quat_x", fld[0], quat_x);
        check_value("quat_y", fld[1], quat_y);
        check_value("quat_z", fld[2], quat_z);
        check_value("quat_w", fld[3], quat_w);
        check_value("gyro words", gyro_before, {gyro_x, gyro_y, gyro_z});
    endtask

    task automatic test_gyroscope;
        int          q0;
        int          g0;
        logic [63:0] quat_before;
        test_name = "gyroscope";
        q0 = quat_pulses;
        g0 = gyro_pulses;
        quat_before = {quat_w, quat_x, quat_y, quat_z};
        push_report(8'h05, 8'h02, 1'b1);   // Continuation bit set in the length
        run_transfer();
        check_value("gyro_valid pulses", g0 + 1, gyro_pulses);
        check_value("quat_valid pulses", q0, quat_pulses);
        check_value("gyro_x", fld[0], gyro_x);
        check_value("gyro_y", fld[1], gyro_y);
        check_value("gyro_z", fld[2], gyro_z);
        check_value("quat words", quat_before, {quat_w, quat_x, quat_y, quat_z});
    endtask

    task automatic test_ignored_frames;
        int           q0;
        int           g0;
        logic [111:0] words_before;
        test_name = "ignored_frames";
        q0 = quat_pulses;
        g0 = gyro_pulses;
        words_before = {quat_w, quat_x, quat_y, quat_z, gyro_x, gyro_y, gyro_z};
        push_report(8'h02, 8'h05, 1'b0);
        run_transfer();
        check_value("quat_valid pulses", q0, quat_pulses);
        check_value("gyro_valid pulses", g0, gyro_pulses);
        check_value("words", words_before,
                    {quat_w, quat_x, quat_y, quat_z, gyro_x, gyro_y, gyro_z});
        push_header(4, 8'h03, 1'b0);
        resp_q.push_back(8'hAA);   // Must stay unread
        resp_q.push_back(8'h55);
        run_transfer();
        check_value("header only bytes", 4, tx_log.size());
        check_value("unread bytes", 2, resp_q.size());
        check_value("cs_n", 1, cs_n);
        resp_q.delete();
    endtask

    task automatic test_timeout;
        int n;
        int limit;
        test_name = "timeout";
        apply_reset();
        limit = `POWERUP_CYCLES + `WAKE_CYCLES + `INT_TIMEOUT + 20;
        n = 0;
        while (!error && n < limit) begin
            @(posedge clk);
            n++;
        end
        check_value("error", 1, error);
        check_value("initialized", 0, initialized);
        // Restart goes through power-up before the next wake pulse
        n = 0;
        while (ps0_wake && n < `POWERUP_CYCLES + 20) begin
            @(posedge clk);
            n++;
        end
        check_value("ps0_wake", 0, ps0_wake);
        n = 0;
        while (!ps0_wake && n < `WAKE_CYCLES + 20) begin
            @(posedge clk);
            n++;
        end
        check_value("ps0_wake released", 1, ps0_wake);
        check_value("error still set", 1, error);
    endtask

    initial begin
        void'($urandom(32'hb889));
        apply_reset();
        test_reset_values();
        test_initialization();
        test_rotation_vector();
        test_gyroscope();
        test_ignored_frames();
        test_timeout();
        if (bno_shtp_top_i.bno_shtp_asserts_i.assert_errors != 0) begin
            $display("%0d assertion failures during the run",
                     bno_shtp_top_i.bno_shtp_asserts_i.assert_errors);
            $display("Regression failed");
            $fatal(1, "Assertion failures");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

/* sim.f */
+incdir+logic
logic/imu_pkg.sv
logic/shtp_sequencer.sv
logic/shtp_frame_decoder.sv
logic/imu_sample_regs.sv
logic/bno_shtp_top.sv
bench/bno_shtp_asserts.sv
bench/bno_shtp_tb.sv
